/* source/capture_pkg.sv */
`default_nettype none

package capture_pkg;

    // Command opcodes, sent as the first byte of an SPI frame
    typedef enum logic [7:0] {
        CMD_PARAM  = 8'h55, // Write PWM trim duty
        CMD_ECHO   = 8'h56, // Echo data bytes back
        CMD_STREAM = 8'h57, // Freeze capture and read the FIFO
        CMD_MODE   = 8'h58  // Write sample mode from bit 7
    } cmd_e;

    typedef enum logic {
        CMD_IDLE = 1'b0, // Next byte is a command
        CMD_DATA = 1'b1  // Next bytes are data for the stored command
    } cmd_state_e;

    // Bytes held by the sample FIFO
    localparam int FIFO_DEPTH = 16;

    // Clocks between samples in mode 1
    localparam int DECIM = 8;

    // Flops in front of every asynchronous input
    localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire

/* source/spi_target.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_target (
    input  logic       clk,
    input  logic       i_reset,
    input  logic       i_spi_sck,
    input  logic       i_spi_cs_n,
    input  logic       i_spi_mosi,
    output logic       o_spi_miso,
    output logic       o_rx_valid,
    output logic [7:0] o_rx_byte,
    input  logic [7:0] i_tx_byte
);

    localparam int NS = capture_pkg::SYNC_STAGES;

    logic [NS-1:0] sck_sync;
    logic [NS-1:0] cs_sync;
    logic [NS-1:0] mosi_sync;
    logic          sck_d;
    logic          sck_s;
    logic          cs_s;
    logic          mosi_s;
    logic          sck_rise;
    logic          sck_fall;
    logic [2:0]    bit_cnt;
    logic [6:0]    rx_shift;
    logic [7:0]    tx_shift;
    logic          tx_load;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            sck_sync  <= '0;
            cs_sync   <= '1; // Idle with chip select released
            mosi_sync <= '0;
            sck_d     <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[NS-2:0], i_spi_sck};
            cs_sync   <= {cs_sync[NS-2:0], i_spi_cs_n};
            mosi_sync <= {mosi_sync[NS-2:0], i_spi_mosi};
            sck_d     <= sck_s;
        end
    end

    assign sck_s    = sck_sync[NS-1];
    assign cs_s     = cs_sync[NS-1];
    assign mosi_s   = mosi_sync[NS-1];
    assign sck_rise = sck_s & ~sck_d;
    assign sck_fall = ~sck_s & sck_d;

    // The response is taken one clock after rx_valid, when the decoder has registered it
    always_ff @(posedge clk) begin
        if (i_reset) begin
            bit_cnt    <= 3'd0;
            o_rx_valid <= 1'b0;
            tx_load    <= 1'b0;
            tx_shift   <= 8'h00;
        end else begin
            o_rx_valid <= 1'b0;
            tx_load    <= o_rx_valid;
            if (cs_s) begin
                bit_cnt  <= 3'd0;
                tx_shift <= 8'h00; // Holds MISO low between frames
            end else begin
                if (sck_rise) begin
                    rx_shift <= {rx_shift[5:0], mosi_s};
                    bit_cnt  <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        o_rx_valid <= 1'b1;
                        o_rx_byte  <= {rx_shift, mosi_s};
                    end
                end
                if (tx_load) begin
                    tx_shift <= i_tx_byte;
                end else if (sck_fall && bit_cnt != 3'd0) begin
                    tx_shift <= {tx_shift[6:0], 1'b0}; // No shift on the fall that ends a byte
                end
            end
        end
    end

    assign o_spi_miso = tx_shift[7];

endmodule

`default_nettype wire

/* source/spi_command.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_command (
    input  logic       clk,
    input  logic       i_reset,
    input  logic       i_cs_n,
    input  logic       i_rx_valid,
    input  logic [7:0] i_rx_byte,
    output logic [7:0] o_tx_byte,
    input  logic [7:0] i_head_byte,
    output logic       o_pause,
    output logic       o_pop,
    output logic       o_mode,
    output logic [7:0] o_duty
);

    localparam int NS = capture_pkg::SYNC_STAGES;

    logic [NS-1:0]           cs_sync;
    logic                    cs_s;
    capture_pkg::cmd_state_e state;
    capture_pkg::cmd_e       addr;
    logic [7:0]              echo;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            cs_sync <= '1;
        end else begin
            cs_sync <= {cs_sync[NS-2:0], i_cs_n};
        end
    end

    assign cs_s = cs_sync[NS-1];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state   <= capture_pkg::CMD_IDLE;
            o_pause <= 1'b0;
            o_pop   <= 1'b0;
            o_duty  <= 8'h00;
            o_mode  <= 1'b0;
            echo    <= 8'h00;
        end else begin
            o_pop <= 1'b0;
            if (cs_s) begin
                state   <= capture_pkg::CMD_IDLE; // End of frame
                o_pause <= 1'b0;
            end else if (i_rx_valid) begin
                if (state == capture_pkg::CMD_IDLE) begin
                    addr  <= capture_pkg::cmd_e'(i_rx_byte);
                    state <= capture_pkg::CMD_DATA;
                    if (i_rx_byte == capture_pkg::CMD_STREAM) begin
                        o_pause <= 1'b1; // Freeze the FIFO before it is read
                    end
                end else begin
                    case (addr)
                        capture_pkg::CMD_PARAM: begin
                            o_duty <= i_rx_byte;
                            state  <= capture_pkg::CMD_IDLE;
                        end
                        capture_pkg::CMD_MODE: begin
                            o_mode <= i_rx_byte[7];
                            state  <= capture_pkg::CMD_IDLE;
                        end
                        capture_pkg::CMD_ECHO: begin
                            echo <= i_rx_byte;
                        end
                        capture_pkg::CMD_STREAM: begin
                            echo  <= i_head_byte; // Reads 0x00 once the FIFO is empty
                            o_pop <= 1'b1;
                        end
                        default: begin
                            state <= capture_pkg::CMD_IDLE;
                        end
                    endcase
                end
            end
        end
    end

    assign o_tx_byte = echo;

endmodule

`default_nettype wire

/* source/digitizer.sv */
`timescale 1ns/1ps
`default_nettype none

module digitizer (
    input  logic clk,
    input  logic i_reset,
    input  logic i_comp,
    input  logic i_mode,
    output logic o_sample_valid,
    output logic o_sample_bit
);

    localparam int NS = capture_pkg::SYNC_STAGES;
    localparam int DW = $clog2(capture_pkg::DECIM);

    logic [NS-1:0] comp_sync;
    logic [DW-1:0] dec_cnt;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            dec_cnt <= '0;
        end else if (dec_cnt == DW'(capture_pkg::DECIM - 1)) begin
            dec_cnt <= '0;
        end else begin
            dec_cnt <= dec_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        comp_sync <= {comp_sync[NS-2:0], i_comp};
    end

    assign o_sample_bit   = comp_sync[NS-1];
    assign o_sample_valid = ~i_mode | (dec_cnt == DW'(capture_pkg::DECIM - 1)); // Every clock in mode 0

endmodule

`default_nettype wire

/* source/sample_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_packer (
    input  logic       clk,
    input  logic       i_reset,
    input  logic       i_sample_valid,
    input  logic       i_sample_bit,
    input  logic       i_pause,
    input  logic       i_pop,
    output logic [7:0] o_head_byte
);

    localparam int DEPTH = capture_pkg::FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic [2:0]    bit_cnt;
    logic [6:0]    shift;
    logic          take;
    logic          push;
    logic          pull;

    assign take = i_sample_valid & ~i_pause;
    assign push = take && (bit_cnt == 3'd7) && (count != (AW+1)'(DEPTH)); // Full FIFO drops the byte
    assign pull = i_pop && (count != '0);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            bit_cnt <= 3'd0;
        end else if (take) begin
            shift   <= {shift[5:0], i_sample_bit};
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {shift, i_sample_bit}; // First sample lands in bit 7
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pull) begin
                count <= count + 1'b1;
            end else if (pull && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign o_head_byte = (count == '0) ? 8'h00 : mem[rd_ptr];

endmodule

`default_nettype wire

/* source/pwm_trim.sv */
`timescale 1ns/1ps
`default_nettype none

module pwm_trim (
    input  logic       clk,
    input  logic       i_reset,
    input  logic [7:0] i_duty,
    output logic       o_pwm
);

    logic [7:0] cnt;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            cnt   <= 8'h00;
            o_pwm <= 1'b0;
        end else begin
            cnt   <= cnt + 8'd1; // Wraps every 256 clocks
            o_pwm <= (cnt < i_duty);
        end
    end

endmodule

`default_nettype wire

/* source/capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_top (
    input  logic clk,
    input  logic i_reset,
    input  logic i_comp,
    input  logic i_spi_sck,
    input  logic i_spi_cs_n,
    input  logic i_spi_mosi,
    output logic o_spi_miso,
    output logic o_pwm
);

    logic       rx_valid;
    logic [7:0] rx_byte;
    logic [7:0] tx_byte;
    logic       pause;
    logic       pop;
    logic [7:0] head_byte;
    logic       mode;
    logic [7:0] duty;
    logic       sample_valid;
    logic       sample_bit;

    spi_target spi_target (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_spi_sck  (i_spi_sck),
        .i_spi_cs_n (i_spi_cs_n),
        .i_spi_mosi (i_spi_mosi),
        .o_spi_miso (o_spi_miso),
        .o_rx_valid (rx_valid),
        .o_rx_byte  (rx_byte),
        .i_tx_byte  (tx_byte)
    );

    spi_command spi_command (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_cs_n      (i_spi_cs_n),
        .i_rx_valid  (rx_valid),
        .i_rx_byte   (rx_byte),
        .o_tx_byte   (tx_byte),
        .i_head_byte (head_byte),
        .o_pause     (pause),
        .o_pop       (pop),
        .o_mode      (mode),
        .o_duty      (duty)
    );

    digitizer digitizer (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_comp         (i_comp),
        .i_mode         (mode),
        .o_sample_valid (sample_valid),
        .o_sample_bit   (sample_bit)
    );

    sample_packer sample_packer (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_sample_valid (sample_valid),
        .i_sample_bit   (sample_bit),
        .i_pause        (pause),
        .i_pop          (pop),
        .o_head_byte    (head_byte)
    );

    pwm_trim pwm_trim (
        .clk     (clk),
        .i_reset (i_reset),
        .i_duty  (duty),
        .o_pwm   (o_pwm)
    );

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

/* verif/capture_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_tb;

    localparam int HALF_CLKS   = 4; // SCK half-period in clocks
    localparam int BYTE_CLKS   = 16 * HALF_CLKS;
    localparam int DEPTH       = capture_pkg::FIFO_DEPTH;
    localparam int REFILL      = DEPTH * 8 + 64;
    localparam int REFILL_DEC  = REFILL * capture_pkg::DECIM;
    localparam int RUN_CLKS    = 167 * BYTE_CLKS + 10 * 3 * HALF_CLKS
                                 + 2 * REFILL + REFILL_DEC + 600;
    localparam int WATCHDOG_NS = 2 * RUN_CLKS * 40;

    logic       clk;
    logic       i_reset;
    logic       i_comp;
    logic       i_spi_sck;
    logic       i_spi_cs_n;
    logic       i_spi_mosi;
    logic       o_spi_miso;
    logic       o_pwm;
    int         errors = 0;
    int         checks = 0;
    int         cs_high_clks = 0;
    integer     seed;
    logic       duty_is_zero;
    logic [7:0] tx_q [$];
    logic [7:0] rx_q [$];

    tb_clock tb_clock (.o_clk(clk));

    capture_top capture_top_inst (.*);

    always @(posedge clk) begin
        cs_high_clks <= i_spi_cs_n ? cs_high_clks + 1 : 0;
    end

    // The shift register clears a few clocks after chip select rises
    assert property (@(posedge clk) disable iff (i_reset)
                     (cs_high_clks >= 4) |-> !o_spi_miso)
        else begin
            errors++;
            $display("** Error at time %0t: o_spi_miso = %b, expected 0",
                     $time, $sampled(o_spi_miso));
        end

    assert property (@(posedge clk) disable iff (i_reset) duty_is_zero |-> !o_pwm)
        else begin
            errors++;
            $display("** Error at time %0t: o_pwm = %b, expected 0", $time, $sampled(o_pwm));
        end

    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic transfer_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int b = 7; b >= 0; b--) begin
            i_spi_mosi = tx[b];
            wait_clks(HALF_CLKS);
            rx[b]     = o_spi_miso; // Host samples MISO as SCK rises
            i_spi_sck = 1'b1;
            wait_clks(HALF_CLKS);
            i_spi_sck = 1'b0;
        end
    endtask

    task automatic run_frame();
        logic [7:0] rx;
        rx_q.delete();
        i_spi_cs_n = 1'b0;
        wait_clks(HALF_CLKS);
        foreach (tx_q[i]) begin
            transfer_byte(tx_q[i], rx);
            rx_q.push_back(rx);
        end
        wait_clks(HALF_CLKS);
        i_spi_cs_n = 1'b1;
        wait_clks(HALF_CLKS);
    endtask

    task automatic send_frame(input logic [7:0] cmd, input logic [7:0] data, input int n);
        tx_q.delete();
        tx_q.push_back(cmd);
        repeat (n) tx_q.push_back(data);
        run_frame();
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at time %0t: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
        end
    endtask

    // Byte n answers during byte n+1, so FIFO data starts at index 2
    task automatic check_stream(input logic [7:0] fill);
        for (int i = 2; i < rx_q.size(); i++) begin
            check_byte($sformatf("o_spi_miso byte %0d", i), rx_q[i],
                       (i <= DEPTH + 1) ? fill : 8'h00);
        end
    endtask

    // The first FIFO byte straddles the previous pause so its bit phase is unknown
    task automatic check_alternating();
        for (int i = 3; i < rx_q.size(); i++) begin
            if (i > DEPTH + 1) begin
                check_byte($sformatf("o_spi_miso byte %0d", i), rx_q[i], 8'h00);
            end else begin
                checks++;
                assert (rx_q[i] == 8'h55 || rx_q[i] == 8'hAA) else begin
                    errors++;
                    $display("** Error at time %0t: o_spi_miso byte %0d = 0x%02h, %s",
                             $time, i, rx_q[i], "expected 0x55 or 0xAA");
                end
                if (i > 3) begin
                    check_byte($sformatf("o_spi_miso byte %0d", i), rx_q[i], rx_q[i - 1]);
                end
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the test sequence did not finish within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int pwm_high;
        int duty;
        seed         = 32'h5c45;
        duty_is_zero = 1'b1;
        i_reset      = 1'b1;
        i_comp       = 1'b1; // FIFO fills with 0xFF from reset on
        i_spi_sck    = 1'b0;
        i_spi_cs_n   = 1'b1;
        i_spi_mosi   = 1'b0;
        wait_clks(4);
        i_reset = 1'b0;
        wait_clks(16);

        tx_q.delete();
        tx_q.push_back(capture_pkg::CMD_ECHO);
        repeat (10) begin
            tx_q.push_back(8'($random(seed)));
            tx_q.push_back(8'hC3); // Dummy with MSB set leaves MISO high as the frame ends
        end
        run_frame();
        for (int i = 2; i < tx_q.size(); i++) begin
            check_byte($sformatf("o_spi_miso byte %0d", i), rx_q[i], tx_q[i - 1]);
        end

        duty_is_zero = 1'b0;
        duty         = $random(seed) & 255;
        send_frame(capture_pkg::CMD_PARAM, 8'(duty), 1);
        wait_clks(300);
        pwm_high = 0;
        repeat (256) begin
            wait_clks(1);
            if (o_pwm) pwm_high++;
        end
        checks++;
        assert (pwm_high == duty) else begin
            errors++;
            $display("** Error at time %0t: o_pwm high count = %0d, expected %0d",
                     $time, pwm_high, duty);
        end

        send_frame(capture_pkg::CMD_STREAM, 8'h00, 21);
        check_stream(8'hFF);

        i_comp = 1'b0;
        send_frame(capture_pkg::CMD_STREAM, 8'h00, 17); // Drain bytes mixed across the edge
        wait_clks(REFILL);
        send_frame(capture_pkg::CMD_STREAM, 8'h00, 21);
        check_stream(8'h00);

        i_comp = 1'b1;
        send_frame(capture_pkg::CMD_STREAM, 8'h00, 17);
        wait_clks(REFILL);
        send_frame(capture_pkg::CMD_STREAM, 8'h00, 21);
        check_stream(8'hFF);

        send_frame(capture_pkg::CMD_MODE, 8'h80, 1);
        fork
            forever begin
                wait_clks(8);
                i_comp = ~i_comp;
            end
        join_none
        send_frame(capture_pkg::CMD_STREAM, 8'h00, 17);
        wait_clks(REFILL_DEC);
        send_frame(capture_pkg::CMD_STREAM, 8'h00, 21);
        check_alternating();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
source/capture_pkg.sv
source/spi_target.sv
source/spi_command.sv
source/digitizer.sv
source/sample_packer.sv
source/pwm_trim.sv
source/capture_top.sv
verif/tb_clock.sv
verif/capture_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module capture_tb -o capture_sim -f all.f

out=$(./obj_dir/capture_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q '^>>> PASS$'
